/* Makefile */
VERILATOR ?= verilator
TOP       ?= softmax_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := hw/softmax_params.svh
DATA := verif/softmax_input.txt
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+hw
hw/softmax_pkg.sv
hw/softmax_lut.sv
hw/exp_store.sv
hw/index_counter.sv
hw/prob_divider.sv
hw/softmax_ctrl.sv
hw/softmax_top.sv
verif/softmax_tb.sv

/* hw/exp_store.sv */
`timescale 1ns/1ps

`include "softmax_params.svh"

module exp_store (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr,
    input  logic               sum_clr,
    input  softmax_pkg::idx_t  wr_idx,
    input  softmax_pkg::exp_t  wr_exp,
    input  softmax_pkg::idx_t  rd_idx,
    output softmax_pkg::exp_t  rd_exp,
    output softmax_pkg::sum_t  sum
);

    softmax_pkg::exp_t mem [`SOFTMAX_LEN];
    softmax_pkg::sum_t acc;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_idx] <= wr_exp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (sum_clr) begin
            acc <= wr ? softmax_pkg::sum_t'(wr_exp) : '0;  // a new vector may start here.
        end else if (wr) begin
            acc <= acc + softmax_pkg::sum_t'(wr_exp);
        end
    end

    assign rd_exp = mem[rd_idx];
    assign sum    = acc;

endmodule

/* hw/index_counter.sv */
`timescale 1ns/1ps

`include "softmax_params.svh"

module index_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              inc,
    output softmax_pkg::idx_t idx,
    output logic              idx_last
);

    softmax_pkg::idx_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (clr) begin
            cnt <= '0;
        end else if (inc) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign idx      = cnt;
    assign idx_last = (cnt == softmax_pkg::idx_t'(`SOFTMAX_LEN - 1));

endmodule

/* hw/prob_divider.sv */
`timescale 1ns/1ps

`include "softmax_params.svh"

module prob_divider (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  softmax_pkg::exp_t  exp_val,
    input  softmax_pkg::sum_t  sum_val,
    output softmax_pkg::prob_t quot,
    output logic               done
);

    localparam int CNT_W = $clog2(`SOFTMAX_DIV_STEPS + 1);
    localparam int REM_W = `SOFTMAX_SUM_W + 1;
    localparam int LO_W  = `SOFTMAX_DATA_W;
    localparam int Q_W   = `SOFTMAX_DIV_STEPS;

    logic [REM_W-1:0]  rem;
    logic [REM_W-1:0]  rem_cur;
    logic [REM_W-1:0]  rem_sh;
    logic [REM_W-1:0]  rem_nx;
    logic [LO_W-1:0]   lo;
    logic [LO_W-1:0]   lo_cur;
    logic [Q_W-1:0]    q;
    logic [Q_W-1:0]    q_cur;
    softmax_pkg::sum_t div_r;
    softmax_pkg::sum_t div_cur;
    logic [CNT_W-1:0]  cnt;
    logic              busy;
    logic              bit_ge;
    logic              step_en;
    logic              last_step;
    logic              ovf_r;
    logic              zero_r;

    // the first quotient bit is resolved on the start edge straight from the inputs.
    always_comb begin
        if (start) begin
            rem_cur = REM_W'(exp_val >> 1);
            lo_cur  = {exp_val[0], {(LO_W - 1){1'b0}}};
            q_cur   = '0;
            div_cur = sum_val;
        end else begin
            rem_cur = rem;
            lo_cur  = lo;
            q_cur   = q;
            div_cur = div_r;
        end
        rem_sh = {rem_cur[REM_W-2:0], lo_cur[LO_W-1]};
        bit_ge = (rem_sh >= REM_W'(div_cur));
        rem_nx = bit_ge ? rem_sh - REM_W'(div_cur) : rem_sh;
    end

    assign last_step = (cnt == CNT_W'(`SOFTMAX_DIV_STEPS));
    assign step_en   = start || (busy && !last_step);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(1);
            end else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // saturation cycle.
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            rem <= rem_nx;
            lo  <= lo_cur << 1;
            q   <= {q_cur[Q_W-2:0], bit_ge};
        end
        if (start) begin
            div_r  <= sum_val;
            ovf_r  <= (softmax_pkg::sum_t'(exp_val >> 1) >= sum_val);  // quotient past 8 bits.
            zero_r <= (sum_val == '0);
        end
        if (busy && last_step) begin
            if (zero_r) begin
                quot <= '0;
            end else if (ovf_r || q[Q_W-1]) begin
                quot <= 8'd127;  // a lone nonzero exponent gives exactly 1.0.
            end else begin
                quot <= q;
            end
        end
    end

endmodule

/* hw/softmax_ctrl.sv */
`timescale 1ns/1ps

module softmax_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  logic out_ready,
    output logic out_valid,
    input  logic idx_last,
    input  logic div_done,
    output logic store_wr,
    output logic sum_clr,
    output logic cnt_clr,
    output logic cnt_inc,
    output logic div_start
);

    softmax_pkg::ctrl_state_t state;
    softmax_pkg::ctrl_state_t state_nx;

    logic in_fire;
    logic out_fire;

    assign in_ready  = (state == softmax_pkg::LOAD);
    assign out_valid = (state == softmax_pkg::EMIT);
    assign div_start = (state == softmax_pkg::DIV_START);

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // the counter walks the vector twice, once to load and once to emit.
    assign store_wr = in_fire;
    assign cnt_inc  = in_fire || out_fire;
    assign cnt_clr  = (in_fire || out_fire) && idx_last;
    assign sum_clr  = out_fire && idx_last;  // next vector starts from zero.

    always_comb begin
        state_nx = state;
        case (state)
            softmax_pkg::LOAD: begin
                if (in_fire && idx_last) begin
                    state_nx = softmax_pkg::DIV_START;
                end
            end
            softmax_pkg::DIV_START: begin
                state_nx = softmax_pkg::DIV_WAIT;
            end
            softmax_pkg::DIV_WAIT: begin
                if (div_done) begin
                    state_nx = softmax_pkg::EMIT;
                end
            end
            softmax_pkg::EMIT: begin
                if (out_fire) begin
                    state_nx = idx_last ? softmax_pkg::LOAD : softmax_pkg::DIV_START;
                end
            end
            default: begin
                state_nx = softmax_pkg::LOAD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= softmax_pkg::LOAD;
        end else begin
            state <= state_nx;
        end
    end

endmodule

/* hw/softmax_lut.sv */
`timescale 1ns/1ps

module softmax_lut (
    input  softmax_pkg::score_t data_in_0,
    output softmax_pkg::exp_t   data_out_0
);

    logic [7:0] code;

    assign code = data_in_0;  // raw code so the ranges compare unsigned.

    always_comb begin
        case (code) inside
            8'h00: data_out_0 = 8'h10;  // exp(0) is 1.0 in Q4.4.
            8'h01: data_out_0 = 8'h11;
            8'h02: data_out_0 = 8'h12;
            8'h03: data_out_0 = 8'h13;
            8'h04: data_out_0 = 8'h15;
            8'h05: data_out_0 = 8'h16;
            8'h06: data_out_0 = 8'h17;
            8'h07: data_out_0 = 8'h19;
            8'h08: data_out_0 = 8'h1A;
            8'h09: data_out_0 = 8'h1C;
            8'h0A: data_out_0 = 8'h1E;
            8'h0B: data_out_0 = 8'h20;
            8'h0C: data_out_0 = 8'h22;
            8'h0D: data_out_0 = 8'h24;
            8'h0E: data_out_0 = 8'h26;
            8'h0F: data_out_0 = 8'h29;
            8'h10: data_out_0 = 8'h2B;
            8'h11: data_out_0 = 8'h2E;
            8'h12: data_out_0 = 8'h31;
            8'h13: data_out_0 = 8'h34;
            8'h14: data_out_0 = 8'h38;
            8'h15: data_out_0 = 8'h3B;
            8'h16: data_out_0 = 8'h3F;
            8'h17: data_out_0 = 8'h43;
            8'h18: data_out_0 = 8'h48;
            8'h19: data_out_0 = 8'h4C;
            8'h1A: data_out_0 = 8'h51;
            8'h1B: data_out_0 = 8'h56;
            8'h1C: data_out_0 = 8'h5C;
            8'h1D: data_out_0 = 8'h62;
            8'h1E: data_out_0 = 8'h68;
            8'h1F: data_out_0 = 8'h6F;
            8'h20: data_out_0 = 8'h76;
            8'h21: data_out_0 = 8'h7E;
            [8'h22:8'h7F]: data_out_0 = 8'h7F;  // saturated from 2.125 upward.
            [8'h80:8'hC8]: data_out_0 = 8'h00;  // below the smallest Q4.4 step.
            [8'hC9:8'hDA]: data_out_0 = 8'h01;
            [8'hDB:8'hE2]: data_out_0 = 8'h02;
            [8'hE3:8'hE7]: data_out_0 = 8'h03;
            [8'hE8:8'hEB]: data_out_0 = 8'h04;
            [8'hEC:8'hEE]: data_out_0 = 8'h05;
            [8'hEF:8'hF1]: data_out_0 = 8'h06;
            [8'hF2:8'hF3]: data_out_0 = 8'h07;
            [8'hF4:8'hF5]: data_out_0 = 8'h08;
            [8'hF6:8'hF7]: data_out_0 = 8'h09;
            [8'hF8:8'hF9]: data_out_0 = 8'h0A;
            8'hFA: data_out_0 = 8'h0B;
            [8'hFB:8'hFC]: data_out_0 = 8'h0C;
            8'hFD: data_out_0 = 8'h0D;
            8'hFE: data_out_0 = 8'h0E;
            8'hFF: data_out_0 = 8'h0F;
            default: data_out_0 = '0;
        endcase
    end

endmodule

/* hw/softmax_params.svh */
`ifndef SOFTMAX_PARAMS_SVH
`define SOFTMAX_PARAMS_SVH

// elements per vector, fixed at build time.
`define SOFTMAX_LEN 8

// scores, exponents and probabilities are all one byte wide.
`define SOFTMAX_DATA_W 8

// wide enough for eight saturated exponents of 127.
`define SOFTMAX_SUM_W 11

`define SOFTMAX_IDX_W 3

// one quotient bit per divider cycle.
`define SOFTMAX_DIV_STEPS 8

`endif

/* hw/softmax_pkg.sv */
`include "softmax_params.svh"

package softmax_pkg;

    typedef logic signed [`SOFTMAX_DATA_W-1:0] score_t;  // signed Q4.4 input score.

    typedef logic [`SOFTMAX_DATA_W-1:0] exp_t;  // unsigned Q4.4 exponent.

    typedef logic [`SOFTMAX_SUM_W-1:0] sum_t;

    typedef logic [`SOFTMAX_DATA_W-1:0] prob_t;  // Q0.7 probability, top bit stays zero.

    typedef logic [`SOFTMAX_IDX_W-1:0] idx_t;

    typedef enum logic [1:0] {
        LOAD,
        DIV_START,
        DIV_WAIT,
        EMIT
    } ctrl_state_t;

endpackage

/* hw/softmax_top.sv */
`timescale 1ns/1ps

module softmax_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  softmax_pkg::score_t in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output softmax_pkg::prob_t  out_data
);

    softmax_pkg::exp_t lut_exp;
    softmax_pkg::exp_t rd_exp;
    softmax_pkg::sum_t sum;
    softmax_pkg::idx_t idx;
    logic              idx_last;
    logic              div_done;
    logic              store_wr;
    logic              sum_clr;
    logic              cnt_clr;
    logic              cnt_inc;
    logic              div_start;

    softmax_lut softmax_lut_inst (
        .data_in_0  (in_data),
        .data_out_0 (lut_exp)
    );

    // one index serves both the write port and the read port.
    exp_store exp_store_inst (
        .clk     (clk),
        .rst     (rst),
        .wr      (store_wr),
        .sum_clr (sum_clr),
        .wr_idx  (idx),
        .wr_exp  (lut_exp),
        .rd_idx  (idx),
        .rd_exp  (rd_exp),
        .sum     (sum)
    );

    index_counter index_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .clr      (cnt_clr),
        .inc      (cnt_inc),
        .idx      (idx),
        .idx_last (idx_last)
    );

    prob_divider prob_divider_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (div_start),
        .exp_val (rd_exp),
        .sum_val (sum),
        .quot    (out_data),
        .done    (div_done)
    );

    softmax_ctrl softmax_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .idx_last  (idx_last),
        .div_done  (div_done),
        .store_wr  (store_wr),
        .sum_clr   (sum_clr),
        .cnt_clr   (cnt_clr),
        .cnt_inc   (cnt_inc),
        .div_start (div_start)
    );

endmodule

/* verif/softmax_input.txt */
# columns: test name, stall mode (1 for random out_ready stalls), eight scores in signed Q4.4 hex,
# then the eight expected Q0.7 probabilities in hex
uniform_zero 0 00 00 00 00 00 00 00 00 10 10 10 10 10 10 10 10
dominant 0 7F 80 80 80 80 80 80 80 7F 00 00 00 00 00 00 00
dominant_mid 1 80 80 80 80 80 7F 80 80 00 00 00 00 00 7F 00 00
zero_sum 0 80 90 A0 B0 C0 C8 C5 81 00 00 00 00 00 00 00 00
mixed_stall 1 10 F0 00 20 E0 08 F8 C9 18 03 09 44 01 0E 05 00
back_to_back_a 0 21 21 21 21 21 21 21 21 10 10 10 10 10 10 10 10
back_to_back_b 0 01 02 03 04 05 06 07 FF 0D 0E 0F 10 11 12 14 0C
lone_small 1 80 80 80 C9 80 80 80 80 00 00 00 7F 00 00 00 00
two_saturated 0 7F 7F 80 80 80 80 80 80 40 40 00 00 00 00 00 00
negative_ramp 1 FF FE FD FC FB FA F9 F8 13 12 11 0F 0F 0E 0D 0D
one_hot_plus 1 22 00 00 00 00 00 00 00 44 08 08 08 08 08 08 08
mixed_repeat 0 10 F0 00 20 E0 08 F8 C9 18 03 09 44 01 0E 05 00

/* verif/softmax_tb.sv */
`timescale 1ns/1ps

`include "softmax_params.svh"

module softmax_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 200;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    softmax_pkg::score_t in_data;
    logic                out_valid;
    logic                out_ready;
    softmax_pkg::prob_t  out_data;

    softmax_pkg::score_t scores [`SOFTMAX_LEN];
    softmax_pkg::prob_t  expected [`SOFTMAX_LEN];
    int                  pass_count;
    int                  fail_count;
    int                  test_errors;
    bit                  timed_out;

    softmax_top softmax_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // every task starts and ends just after a rising edge; handshakes are sampled at the falling edge.
    task automatic send_vector(input string name);
        int  gap;
        int  guard;
        bit  accepted;
        for (int i = 0; i < `SOFTMAX_LEN; i++) begin
            gap = $urandom_range(0, 2);
            in_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            in_valid = 1'b1;
            in_data  = scores[i];
            accepted = 1'b0;
            guard    = 0;
            while (!accepted && guard < WAIT_LIMIT) begin
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
                #DRIVE_DELAY;
                guard++;
            end
            if (!accepted) begin
                $display("timeout in %s: in_ready never rose for score %0d", name, i);
                timed_out = 1'b1;
                in_valid  = 1'b0;
                return;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_vector(input string name, input bit stall_mode);
        int                 guard;
        bit                 got;
        bit                 held_valid;
        softmax_pkg::prob_t held_data;
        softmax_pkg::prob_t value;
        for (int i = 0; i < `SOFTMAX_LEN; i++) begin
            got        = 1'b0;
            guard      = 0;
            held_valid = 1'b0;
            while (!got && guard < WAIT_LIMIT) begin
                out_ready = stall_mode ? ($urandom_range(0, 2) != 0) : 1'b1;
                @(negedge clk);
                assert (!in_ready) else begin
                    $display("%s element %0d: in_ready rose before the vector was emitted", name, i);
                    test_errors++;
                end
                if (held_valid) begin
                    assert (out_valid && out_data == held_data) else begin
                        $display("%s element %0d: output changed while stalled", name, i);
                        test_errors++;
                    end
                end
                held_valid = out_valid && !out_ready;
                held_data  = out_data;
                if (out_valid && out_ready) begin
                    got   = 1'b1;
                    value = out_data;
                end
                @(posedge clk);
                #DRIVE_DELAY;
                guard++;
            end
            if (!got) begin
                $display("timeout in %s: out_valid never rose for element %0d", name, i);
                timed_out = 1'b1;
                out_ready = 1'b0;
                return;
            end
            assert (value == expected[i]) else begin
                $display("[FAIL] %s element %0d: expected %02h, actual %02h",
                         name, i, expected[i], value);
                test_errors++;
            end
        end
        out_ready = 1'b0;
    endtask

    task automatic run_test(input string name, input bit stall_mode);
        test_errors = 0;
        send_vector(name);
        if (!timed_out) begin
            collect_vector(name, stall_mode);
        end
        if (test_errors == 0 && !timed_out) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    val;
        int    stall;
        string name;
        string line;
        void'($urandom(93354));
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        fd = $fopen("verif/softmax_input.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/softmax_input.txt");
        end
        while (fd != 0 && !timed_out) begin
            n = $fscanf(fd, "%s", name);
            if (n != 1) begin
                break;
            end
            if (name.substr(0, 0) == "#") begin
                void'($fgets(line, fd));  // skip the rest of a comment line.
            end else begin
                n = $fscanf(fd, "%d", stall);
                for (int i = 0; i < `SOFTMAX_LEN; i++) begin
                    n = $fscanf(fd, "%h", val);
                    scores[i] = softmax_pkg::score_t'(val);
                end
                for (int i = 0; i < `SOFTMAX_LEN; i++) begin
                    n = $fscanf(fd, "%h", val);
                    expected[i] = softmax_pkg::prob_t'(val);
                end
                run_test(name, stall != 0);
            end
        end
        $display("passed tests: %0d, failed tests: %0d", pass_count, fail_count);
        if (fd != 0 && !timed_out && fail_count == 0 && pass_count > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
